// ==== ctrlDefs_defs.svh ====
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// ****************************************
// widths
`define INSTR_W     16                      // instruction word
`define ADDR_W      16                      // program address
`define REG_SEL_W   4                       // register file select
`define ALU_OP_W    4                       // alu mode code

// ****************************************
// start-up and stack
`define START_DELAY 40                      // start cycles before first fetch
`define SP_LOW_REG  14                      // low byte of the stack pointer

// ****************************************
// interrupts, line 0 wins
`define IRQ_N       4
`define IRQ_VEC0    16'd20
`define IRQ_VEC1    16'd30
`define IRQ_VEC2    16'd40
`define IRQ_VEC3    16'd50

`endif

// ==== ctrlPkg.sv ====
`include "ctrlDefs_defs.svh"

package ctrlPkg;

    typedef enum logic [2:0] {
        Part1, Part2, Part3, JmpFetch, CallFetch, IrqPush, Start
    } seqState_t;

    typedef enum logic [3:0] {
        AluImm, AluReg, PortIo, Branch, JumpLong, CallLong, Return, NopHalt, Unknown
    } instrClass_t;

    // condition field, instruction bits 15:13
    typedef enum logic [2:0] {
        Always, Carry, NoCarry, Zero, NonZero, Negative, Positive, AlwaysAlt
    } condCode_t;

    typedef enum logic [2:0] {
        PcOut = 3'd0, PcPlusOne = 3'd1, IrqVector = 3'd2, MemWord = 3'd3,
        BranchRel = 3'd4, ReturnAddr = 3'd5, BranchReg = 3'd6
    } addrSrc_t;

    typedef enum logic [2:0] {
        AluOut = 3'd0, PcPlusOneHigh = 3'd1, PcPlusOneLow = 3'd2, PcHigh = 3'd3, PcLow = 3'd4
    } dataSrc_t;

    typedef enum logic [1:0] {
        PtrPair = 2'd0, PortImm = 2'd1, PtrPairPlusOne = 2'd2
    } ioAddrSrc_t;

    typedef enum logic [1:0] {
        AluFlags = 2'd0, ClearIrqEnable = 2'd3
    } statusSrc_t;

    typedef struct packed {
        logic                   regFileSrc;         // 0 alu, 1 data memory / io
        logic [`REG_SEL_W-1:0]  regFileOutBSelect;
        logic                   regFileWriteEnable;
        logic                   regFileAdd;
        logic [1:0]             regFileConstSrc;
        logic [1:0]             aluSrcBSelect;
        logic [`ALU_OP_W-1:0]   aluMode;
        dataSrc_t               dMemDataSelect;
        ioAddrSrc_t             dMemIOAddressSelect;
        logic                   dMemIOWriteEn;
        logic                   dMemIOReadEn;
        statusSrc_t             statusRegSrcSelect;
        logic                   flagEnable;
        addrSrc_t               iMemAddrSelect;
        logic                   iMemReadEnable;
        logic                   pcWriteEn;
    } ctrlWord_t;

endpackage

// ==== decodeIf.sv ====
`timescale 1ns/1ps

`include "ctrlDefs_defs.svh"

interface decodeIf import ctrlPkg::*; ();

    instrClass_t            instrClass;
    logic                   condMet;            // condition field true
    logic                   isPortIn;           // IN rather than OUT
    logic                   flagUpdate;         // low for LDI and MOV
    logic                   uninterruptible;    // HLT
    logic                   branchReg;          // register-indirect branch
    logic [`ALU_OP_W-1:0]   aluOp;

    modport decoder (
        output instrClass, condMet, isPortIn, flagUpdate, uninterruptible, branchReg, aluOp
    );

    modport sequencer (
        input instrClass, condMet, isPortIn, flagUpdate, uninterruptible, branchReg, aluOp
    );

endinterface

// ==== instrDecoder.sv ====
`timescale 1ns/1ps

`include "ctrlDefs_defs.svh"

module instrDecoder
    import ctrlPkg::*;
(
    input  logic [`INSTR_W-1:0] instrWord,
    input  logic                carryFlag,
    input  logic                zeroFlag,
    input  logic                negativeFlag,
    decodeIf.decoder            dec
);

    logic aluImmType, portIoType, aluRegType, singleRegType;
    logic brType, jmpIndType, jmpType, callType, retType;
    logic nopType, hltType;
    condCode_t condCode;

    // ****************************************
    // instruction classes
    assign aluImmType    = (instrWord[3:0] >= 4'd1) && (instrWord[3:0] <= 4'd7);
    assign portIoType    = (instrWord[3:1] == 3'b100);
    assign aluRegType    = (instrWord[3:0] == 4'b1010) && (instrWord[7:4] >= 4'd1)
                           && (instrWord[7:4] <= 4'd9);
    assign singleRegType = (instrWord[3:0] == 4'b1111) && (instrWord[7:4] >= 4'b1010)
                           && (instrWord[11:8] == 4'b0000);
    assign brType        = (instrWord[3:0] == 4'b1110);
    assign jmpIndType    = (instrWord[8:0] == 9'b0_0001_1111) && !instrWord[12];
    assign jmpType       = (instrWord[12:0] == 13'b0_0000_0010_1111);
    assign callType      = (instrWord[12:0] == 13'b0_0000_0011_1111);
    assign retType       = (instrWord[12:0] == 13'b0_0000_0100_1111);
    assign nopType       = (instrWord == '0);
    assign hltType       = (instrWord == '1);

    // ****************************************
    // branch condition
    assign condCode = condCode_t'(instrWord[15:13]);

    always_comb begin
        case (condCode)
            Carry:    dec.condMet = carryFlag;
            NoCarry:  dec.condMet = !carryFlag;
            Zero:     dec.condMet = zeroFlag;
            NonZero:  dec.condMet = !zeroFlag;
            Negative: dec.condMet = negativeFlag;
            Positive: dec.condMet = !negativeFlag;
            default:  dec.condMet = 1'b1;       // both always codes
        endcase
    end

    assign dec.uninterruptible = hltType;
    assign dec.isPortIn = !instrWord[0];    // only read for the port class
    assign dec.branchReg = jmpIndType;

    always_comb begin
        dec.instrClass = Unknown;
        dec.flagUpdate = 1'b0;
        dec.aluOp = '0;                         // pass A
        if (aluImmType) begin
            dec.instrClass = AluImm;
            dec.aluOp = {1'b0, instrWord[2:0]};
            dec.flagUpdate = (instrWord[3:1] != 3'b001);   // no flags on LDI
        end else if (portIoType) begin
            dec.instrClass = PortIo;
        end else if (aluRegType || singleRegType) begin
            dec.instrClass = AluReg;
            dec.aluOp = instrWord[7:4];
            dec.flagUpdate = (instrWord[7:4] != 4'b1000);  // MOV leaves flags
        end else if (brType || jmpIndType) begin
            dec.instrClass = Branch;
        end else if (jmpType) begin
            dec.instrClass = JumpLong;
        end else if (callType) begin
            dec.instrClass = CallLong;
        end else if (retType) begin
            dec.instrClass = Return;
        end else if (nopType || hltType) begin
            dec.instrClass = NopHalt;
        end
    end

endmodule

// ==== irqVectorUnit.sv ====
`timescale 1ns/1ps

`include "ctrlDefs_defs.svh"

module irqVectorUnit (
    input  logic [`IRQ_N-1:0]   irqRequest,
    input  logic                irqTake,
    output logic                irqPending,
    output logic [`ADDR_W-1:0]  interruptVector,
    output logic [`IRQ_N-1:0]   irqClear
);

    localparam logic [`ADDR_W-1:0] vecTable [`IRQ_N] = '{
        `IRQ_VEC0, `IRQ_VEC1, `IRQ_VEC2, `IRQ_VEC3
    };

    logic [`IRQ_N-1:0] winner;              // one-hot, highest priority line

    // scan from the lowest priority so line 0 has the last word
    always_comb begin
        winner = '0;
        interruptVector = '0;
        for (int i = `IRQ_N - 1; i >= 0; i--) begin
            if (irqRequest[i]) begin
                winner = '0;
                winner[i] = 1'b1;
                interruptVector = vecTable[i];
            end
        end
    end

    assign irqPending = |irqRequest;
    assign irqClear = irqTake ? winner : '0;   // one pulse during the high-byte push

endmodule

// ==== controlSequencer.sv ====
`timescale 1ns/1ps

`include "ctrlDefs_defs.svh"

module controlSequencer
    import ctrlPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    decodeIf.sequencer              dec,
    input  logic                    interruptEnable,
    input  logic                    irqPending,
    output logic                    irqTake,
    input  logic [`REG_SEL_W-1:0]   regSelField,
    output ctrlWord_t               ctrl
);

    localparam int delayW = $clog2(`START_DELAY + 1);
    localparam logic [delayW-1:0] delayDone = delayW'(`START_DELAY);
    localparam logic [`REG_SEL_W-1:0] spLowReg = `REG_SEL_W'(`SP_LOW_REG);

    seqState_t          state;
    seqState_t          nextState;
    logic [delayW-1:0]  delayCnt;
    logic               startDone;
    logic               takeIrq;
    logic               portRead;           // first cycle of IN
    logic               retPop;             // stack read cycles of a taken RET
    logic               retDone;

    // push one byte through the stack pointer pair, SP decrements
    function automatic ctrlWord_t stackPush(ctrlWord_t base, dataSrc_t src);
        ctrlWord_t word;
        word = base;
        word.regFileOutBSelect = spLowReg;
        word.regFileAdd = 1'b1;
        word.regFileConstSrc = 2'b01;
        word.dMemDataSelect = src;
        word.dMemIOAddressSelect = PtrPair;
        word.dMemIOWriteEn = 1'b1;
        return word;
    endfunction

    // ****************************************
    // state register and start delay
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Start;
            delayCnt <= '0;
        end else begin
            state <= nextState;
            if (state == Start) begin
                delayCnt <= delayCnt + 1'b1;
            end else begin
                delayCnt <= '0;
            end
        end
    end

    assign startDone = (delayCnt == delayDone);
    assign takeIrq = (state == Part1) && interruptEnable && irqPending && !dec.uninterruptible;
    assign irqTake = (state == IrqPush);
    assign portRead = dec.isPortIn && (state == Part1);
    assign retPop = ((state == Part1) && dec.condMet) || (state == Part2);
    assign retDone = ((state == Part1) && !dec.condMet) || (state == Part3);

    // ****************************************
    // control word, defaults are a plain advance
    always_comb begin
        ctrl = '0;
        ctrl.regFileOutBSelect = regSelField;
        ctrl.iMemReadEnable = 1'b1;
        ctrl.pcWriteEn = 1'b1;
        nextState = Part1;
        case (state)
            Start: begin
                ctrl.iMemReadEnable = startDone;    // first fetch
                ctrl.pcWriteEn = startDone;
                nextState = startDone ? Part1 : Start;
            end
            JmpFetch: begin
                ctrl.iMemAddrSelect = MemWord;      // target from second word
            end
            CallFetch: begin
                ctrl = stackPush(ctrl, PcPlusOneHigh);
                ctrl.iMemAddrSelect = MemWord;
            end
            IrqPush: begin
                ctrl = stackPush(ctrl, PcHigh);
                ctrl.statusRegSrcSelect = ClearIrqEnable;
                ctrl.flagEnable = 1'b1;
                ctrl.iMemAddrSelect = IrqVector;
            end
            default: begin
                if (takeIrq) begin
                    ctrl = stackPush(ctrl, PcLow);
                    ctrl.statusRegSrcSelect = ClearIrqEnable;   // mask further requests
                    ctrl.flagEnable = 1'b1;
                    ctrl.iMemAddrSelect = IrqVector;
                    ctrl.iMemReadEnable = 1'b0;
                    ctrl.pcWriteEn = 1'b0;
                    nextState = IrqPush;
                end else begin
                    case (dec.instrClass)
                        AluImm: begin
                            ctrl.regFileWriteEnable = 1'b1;
                            ctrl.aluSrcBSelect = 2'b10;         // 8-bit immediate
                            ctrl.aluMode = dec.aluOp;
                            ctrl.flagEnable = dec.flagUpdate;
                        end
                        AluReg: begin
                            ctrl.regFileWriteEnable = 1'b1;
                            ctrl.aluMode = dec.aluOp;
                            ctrl.flagEnable = dec.flagUpdate;
                        end
                        PortIo: begin
                            ctrl.regFileSrc = 1'b1;             // io data in
                            ctrl.dMemIOAddressSelect = PortImm;
                            ctrl.dMemIOWriteEn = !dec.isPortIn;
                            ctrl.dMemIOReadEn = portRead;
                            ctrl.regFileWriteEnable = dec.isPortIn && (state == Part2);
                            ctrl.iMemReadEnable = !portRead;
                            ctrl.pcWriteEn = !portRead;
                            nextState = portRead ? Part2 : Part1;
                        end
                        Branch: begin
                            if (dec.condMet) begin
                                ctrl.iMemAddrSelect = dec.branchReg ? BranchReg : BranchRel;
                            end
                        end
                        JumpLong: begin
                            ctrl.iMemAddrSelect = dec.condMet ? PcOut : PcPlusOne;
                            ctrl.pcWriteEn = !dec.condMet;
                            nextState = dec.condMet ? JmpFetch : Part1;
                        end
                        CallLong: begin
                            if (dec.condMet) begin
                                ctrl = stackPush(ctrl, PcPlusOneLow);
                            end
                            ctrl.iMemAddrSelect = dec.condMet ? PcOut : PcPlusOne;
                            ctrl.pcWriteEn = !dec.condMet;      // high byte still to push
                            nextState = dec.condMet ? CallFetch : Part1;
                        end
                        Return: begin
                            ctrl.regFileOutBSelect = spLowReg;
                            ctrl.regFileAdd = retPop;
                            ctrl.dMemIOAddressSelect = PtrPairPlusOne;
                            ctrl.dMemIOReadEn = retPop;
                            ctrl.iMemAddrSelect = (state == Part1) ? PcOut : ReturnAddr;
                            ctrl.iMemReadEnable = retDone;
                            ctrl.pcWriteEn = retDone;
                            if (!retDone) begin
                                nextState = (state == Part1) ? Part2 : Part3;
                            end
                        end
                        NopHalt: begin
                            ctrl.iMemReadEnable = !dec.uninterruptible;   // HLT parks here
                            ctrl.pcWriteEn = !dec.uninterruptible;
                        end
                        default: ;                  // unknown word, one-cycle no-op
                    endcase
                end
            end
        endcase
    end

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps

`include "ctrlDefs_defs.svh"

module controlUnit
    import ctrlPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`INSTR_W-1:0]     iMemOut,
    input  logic                    carryFlag,
    input  logic                    zeroFlag,
    input  logic                    negativeFlag,
    input  logic                    interruptEnable,
    input  logic [`IRQ_N-1:0]       irqRequest,
    output logic                    regFileSrc,
    output logic [`REG_SEL_W-1:0]   regFileOutBSelect,
    output logic                    regFileWriteEnable,
    output logic                    regFileAdd,
    output logic [1:0]              regFileConstSrc,
    output logic [1:0]              aluSrcBSelect,
    output logic [`ALU_OP_W-1:0]    aluMode,
    output logic [2:0]              dMemDataSelect,
    output logic [1:0]              dMemIOAddressSelect,
    output logic                    dMemIOWriteEn,
    output logic                    dMemIOReadEn,
    output logic [1:0]              statusRegSrcSelect,
    output logic                    flagEnable,
    output logic [2:0]              iMemAddrSelect,
    output logic                    iMemReadEnable,
    output logic                    pcWriteEn,
    output logic [`ADDR_W-1:0]      interruptVector,
    output logic [`IRQ_N-1:0]       irqClear
);

    decodeIf   decBus ();
    ctrlWord_t ctrl;
    logic      irqPending;
    logic      irqTake;

    instrDecoder i_instrDecoder (
        .instrWord    (iMemOut),
        .carryFlag    (carryFlag),
        .zeroFlag     (zeroFlag),
        .negativeFlag (negativeFlag),
        .dec          (decBus.decoder)
    );

    irqVectorUnit i_irqVectorUnit (
        .irqRequest      (irqRequest),
        .irqTake         (irqTake),
        .irqPending      (irqPending),
        .interruptVector (interruptVector),
        .irqClear        (irqClear)
    );

    controlSequencer i_controlSequencer (
        .clk             (clk),
        .rst             (rst),
        .dec             (decBus.sequencer),
        .interruptEnable (interruptEnable),
        .irqPending      (irqPending),
        .irqTake         (irqTake),
        .regSelField     (iMemOut[11:8]),     // register field of the word
        .ctrl            (ctrl)
    );

    // ****************************************
    // control word out to the datapath
    assign regFileSrc          = ctrl.regFileSrc;
    assign regFileOutBSelect   = ctrl.regFileOutBSelect;
    assign regFileWriteEnable  = ctrl.regFileWriteEnable;
    assign regFileAdd          = ctrl.regFileAdd;
    assign regFileConstSrc     = ctrl.regFileConstSrc;
    assign aluSrcBSelect       = ctrl.aluSrcBSelect;
    assign aluMode             = ctrl.aluMode;
    assign dMemDataSelect      = ctrl.dMemDataSelect;
    assign dMemIOAddressSelect = ctrl.dMemIOAddressSelect;
    assign dMemIOWriteEn       = ctrl.dMemIOWriteEn;
    assign dMemIOReadEn        = ctrl.dMemIOReadEn;
    assign statusRegSrcSelect  = ctrl.statusRegSrcSelect;
    assign flagEnable          = ctrl.flagEnable;
    assign iMemAddrSelect      = ctrl.iMemAddrSelect;
    assign iMemReadEnable      = ctrl.iMemReadEnable;
    assign pcWriteEn           = ctrl.pcWriteEn;

endmodule

// ==== controlUnit_sva.sv ====
`timescale 1ns/1ps

`include "ctrlDefs_defs.svh"

module controlUnit_sva
    import ctrlPkg::*;
(
    input logic         clk,
    input logic         rst,
    input seqState_t    state,
    input logic         irqTake,
    input ctrlWord_t    ctrl
);

    int unsigned startCycles;               // cycles spent in Start since reset

    always_ff @(posedge clk) begin
        if (rst) begin
            startCycles <= 0;
        end else if (state == Start) begin
            startCycles <= startCycles + 1;
        end
    end

    // ****************************************
    // sequencer rules
    // clear pulse comes with the high-byte push, right after the low byte went out
    irqTakeOnlyInPush: assert property (
        @(posedge clk) disable iff (rst)
        irqTake |-> (ctrl.dMemDataSelect == PcHigh) && $past(ctrl.dMemDataSelect == PcLow)
    ) else $error("irqTake raised outside the IrqPush state");

    ioNotBothWays: assert property (
        @(posedge clk) disable iff (rst) !(ctrl.dMemIOWriteEn && ctrl.dMemIOReadEn)
    ) else $error("io write and io read enabled in the same cycle");

    // no PC load until the start delay has run out
    pcQuietInStart: assert property (
        @(posedge clk) disable iff (rst)
        ((state == Start) && (startCycles < `START_DELAY)) |-> !ctrl.pcWriteEn
    ) else $error("pcWriteEn high during the start delay");

endmodule

bind controlSequencer controlUnit_sva sequencerChecks (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .irqTake   (irqTake),
    .ctrl      (ctrl)
);

// ==== controlUnit_tb.sv ====
`timescale 1ns/1ps

`include "ctrlDefs_defs.svh"

module controlUnit_tb;

    localparam int halfPeriod = 10;
    localparam int maxCycles = 400;         // far above the vector file length
    localparam int fieldsPerLine = 22;

    logic                   clk;
    logic                   rst;
    logic [`INSTR_W-1:0]    iMemOut;
    logic                   carryFlag;
    logic                   zeroFlag;
    logic                   negativeFlag;
    logic                   interruptEnable;
    logic [`IRQ_N-1:0]      irqRequest;

    logic                   regFileSrc;
    logic [`REG_SEL_W-1:0]  regFileOutBSelect;
    logic                   regFileWriteEnable;
    logic                   regFileAdd;
    logic [1:0]             regFileConstSrc;
    logic [1:0]             aluSrcBSelect;
    logic [`ALU_OP_W-1:0]   aluMode;
    logic [2:0]             dMemDataSelect;
    logic [1:0]             dMemIOAddressSelect;
    logic                   dMemIOWriteEn;
    logic                   dMemIOReadEn;
    logic [1:0]             statusRegSrcSelect;
    logic                   flagEnable;
    logic [2:0]             iMemAddrSelect;
    logic                   iMemReadEnable;
    logic                   pcWriteEn;
    logic [`ADDR_W-1:0]     interruptVector;
    logic [`IRQ_N-1:0]      irqClear;

    int             fd;
    int             cycleCount;
    int             fieldCount;
    bit             finished;
    string          lineText;
    string          firstWord;
    logic [31:0]    stim [7];               // count, word, c, z, n, ie, irq
    logic [31:0]    expVal [15];

    controlUnit i_controlUnit (.*);

    always #halfPeriod clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("Error at %0t ns: %s is %0h, expected %0h",
                               $time, name, actual, expected));
        end
    endtask

    // ****************************************
    // vector file handling
    task automatic readVector();
        bit gotLine;
        gotLine = 1'b0;
        while (!gotLine && !finished) begin
            if ($fgets(lineText, fd) == 0) begin
                abortRun("vector file ended before the end marker");
            end
            firstWord = "";
            void'($sscanf(lineText, "%s", firstWord));
            if (firstWord == "end") begin
                finished = 1'b1;
            end else if (firstWord.len() > 0 && firstWord.getc(0) != 8'h23) begin
                fieldCount = $sscanf(lineText,
                    "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    stim[0], stim[1], stim[2], stim[3], stim[4], stim[5], stim[6],
                    expVal[0], expVal[1], expVal[2], expVal[3], expVal[4],
                    expVal[5], expVal[6], expVal[7], expVal[8], expVal[9],
                    expVal[10], expVal[11], expVal[12], expVal[13], expVal[14]);
                if (fieldCount != fieldsPerLine) begin
                    abortRun($sformatf("bad vector line: %s", lineText));
                end
                gotLine = 1'b1;
            end
        end
    endtask

    task automatic applyStimulus();
        iMemOut = stim[1][`INSTR_W-1:0];
        carryFlag = stim[2][0];
        zeroFlag = stim[3][0];
        negativeFlag = stim[4][0];
        interruptEnable = stim[5][0];
        irqRequest = stim[6][`IRQ_N-1:0];
    endtask

    task automatic checkOutputs();
        logic [3:0] opLow;
        opLow = stim[1][3:0];
        checkValue("regFileWriteEnable", 32'(regFileWriteEnable), expVal[0]);
        checkValue("regFileAdd", 32'(regFileAdd), expVal[1]);
        checkValue("regFileOutBSelect", 32'(regFileOutBSelect), expVal[2]);
        checkValue("aluMode", 32'(aluMode), expVal[3]);
        checkValue("dMemDataSelect", 32'(dMemDataSelect), expVal[4]);
        checkValue("dMemIOAddressSelect", 32'(dMemIOAddressSelect), expVal[5]);
        checkValue("dMemIOWriteEn", 32'(dMemIOWriteEn), expVal[6]);
        checkValue("dMemIOReadEn", 32'(dMemIOReadEn), expVal[7]);
        checkValue("statusRegSrcSelect", 32'(statusRegSrcSelect), expVal[8]);
        checkValue("flagEnable", 32'(flagEnable), expVal[9]);
        checkValue("iMemAddrSelect", 32'(iMemAddrSelect), expVal[10]);
        checkValue("iMemReadEnable", 32'(iMemReadEnable), expVal[11]);
        checkValue("pcWriteEn", 32'(pcWriteEn), expVal[12]);
        checkValue("interruptVector", 32'(interruptVector), expVal[13]);
        checkValue("irqClear", 32'(irqClear), expVal[14]);
        // register writes take io data only on port lines
        if (expVal[0] == 1) begin
            checkValue("regFileSrc", 32'(regFileSrc), 32'(expVal[5] == 1));
            if (expVal[5] != 1) begin
                checkValue("aluSrcBSelect", 32'(aluSrcBSelect),
                           (opLow >= 4'd1 && opLow <= 4'd7) ? 32'd2 : 32'd0);
            end
        end
        // stack pointer steps down on a push, up on a pop
        if (expVal[1] == 1) begin
            checkValue("regFileConstSrc", 32'(regFileConstSrc),
                       (expVal[6] == 1) ? 32'd1 : 32'd0);
        end
    endtask

    // ****************************************
    // main sequence
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        iMemOut = '0;
        carryFlag = 1'b0;
        zeroFlag = 1'b0;
        negativeFlag = 1'b0;
        interruptEnable = 1'b0;
        irqRequest = '0;
        finished = 1'b0;
        cycleCount = 0;
        fd = $fopen("controlUnit_vectors.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open controlUnit_vectors.txt");
        end
        repeat (10) @(posedge clk);
        readVector();
        while (!finished) begin
            for (int i = 0; i < int'(stim[0]); i++) begin
                @(negedge clk);
                rst = 1'b0;                 // first vector is the first cycle out of reset
                applyStimulus();
                #(halfPeriod - 1);          // just ahead of the rising edge
                checkOutputs();
                cycleCount++;
                if (cycleCount > maxCycles) begin
                    abortRun("cycle limit reached before the end marker");
                end
            end
            readVector();
        end
        $fclose(fd);
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== controlUnit_vectors.txt ====
# cnt instr c z n ie irq | expected: rfWe rfAdd bSel alu dSel ioSel ioWe ioRe st flagEn iSel iRe pcWe vec clr
# count is decimal and repeats the line, every other column is hex
# start delay, then first fetch, then a NOP in Part1
40 0000 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 0 0 0000 0
1  0000 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 1 1 0000 0
1  0000 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 1 1 0000 0
# alu immediate: ADDI, LDI without flags
1  0301 0 0 0 0 0  1 0 3 1 0 0 0 0 0 1 0 1 1 0000 0
1  0502 0 0 0 0 0  1 0 5 2 0 0 0 0 0 0 0 1 1 0000 0
# register alu: ADD, MOV without flags, single register op
1  021a 0 0 0 0 0  1 0 2 1 0 0 0 0 0 1 0 1 1 0000 0
1  048a 0 0 0 0 0  1 0 4 8 0 0 0 0 0 0 0 1 1 0000 0
1  00bf 0 0 0 0 0  1 0 0 b 0 0 0 0 0 1 0 1 1 0000 0
# IN over two cycles, OUT in one
1  0608 0 0 0 0 0  0 0 6 0 0 1 0 1 0 0 0 0 0 0000 0
1  0608 0 0 0 0 0  1 0 6 0 0 1 0 0 0 0 0 1 1 0000 0
1  0709 0 0 0 0 0  0 0 7 0 0 1 1 0 0 0 0 1 1 0000 0
# branch on zero, false then true, then register indirect
1  600e 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 1 1 0000 0
1  600e 0 1 0 0 0  0 0 0 0 0 0 0 0 0 0 4 1 1 0000 0
1  021f 0 0 0 0 0  0 0 2 0 0 0 0 0 0 0 6 1 1 0000 0
# JMP on carry false, JMP always with its target word
1  202f 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 1 1 1 0000 0
1  002f 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 1 0 0000 0
1  1234 0 0 0 0 0  0 0 2 0 0 0 0 0 0 0 3 1 1 0000 0
# CALL on non-zero false, CALL always pushes low then high
1  803f 0 1 0 0 0  0 0 0 0 0 0 0 0 0 0 1 1 1 0000 0
1  003f 0 0 0 0 0  0 1 e 0 2 0 1 0 0 0 0 1 0 0000 0
1  0200 0 0 0 0 0  0 1 e 0 1 0 1 0 0 0 3 1 1 0000 0
# RET always over three cycles, RET on negative false
1  004f 0 0 0 0 0  0 1 e 0 0 2 0 1 0 0 0 0 0 0000 0
1  004f 0 0 0 0 0  0 1 e 0 0 2 0 1 0 0 5 0 0 0000 0
1  004f 0 0 0 0 0  0 0 e 0 0 2 0 0 0 0 5 1 1 0000 0
1  a04f 0 0 0 0 0  0 0 e 0 0 2 0 0 0 0 0 1 1 0000 0
# word that decodes to nothing
1  0010 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 1 1 0000 0
# lines 1 and 2 request, line 1 wins with vector 30
1  0000 0 0 0 1 6  0 1 e 0 4 0 1 0 3 1 2 0 0 001e 0
1  0000 0 0 0 1 6  0 1 e 0 3 0 1 0 3 1 2 1 1 001e 2
1  0000 0 0 0 0 6  0 0 0 0 0 0 0 0 0 0 0 1 1 001e 0
# HLT holds even with a request pending
3  ffff 0 0 0 1 6  0 0 f 0 0 0 0 0 0 0 0 0 0 001e 0
1  0000 0 0 0 0 8  0 0 0 0 0 0 0 0 0 0 0 1 1 0032 0
1  0000 0 0 0 0 0  0 0 0 0 0 0 0 0 0 0 0 1 1 0000 0
end

// ==== sources.f ====
+incdir+.
ctrlPkg.sv
decodeIf.sv
instrDecoder.sv
irqVectorUnit.sv
controlSequencer.sv
controlUnit.sv
controlUnit_sva.sv
controlUnit_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module controlUnit_tb -f sources.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Verification passed" sim.log && echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }
